/* bench/ise_tb.sv */
`timescale 1ns/10ps

module ise_tb;

// --------------------
// Test lengths
localparam int RESET_CYCLES = 16;
localparam int N_PAIRS      = 24;               // mv2cop / mv2gpr pairs
localparam int N_HALF       = 8;                // lui / lli rounds
localparam int N_CMOV       = 12;               // Conditional move rounds
localparam int N_BAD        = 7;                // Illegal encodings
// Every cycle of every section, idle gaps included
localparam int TOTAL_STEPS  = RESET_CYCLES + 1 + 16 + 2*N_PAIRS + 2*(N_PAIRS/4)
                            + 5*N_HALF + 5*N_CMOV + N_BAD + 16 + 4;

logic                  g_clk;
logic                  g_resetn;
logic                  cop_insn_valid;
ise_pkg::xlen_t        cop_insn_enc;
ise_pkg::xlen_t        cop_rs1;
ise_pkg::ise_result_t  cop_result;
ise_pkg::cpr_mask_t    cop_cprs_written;
ise_pkg::cpr_mask_t    cop_cprs_read;
logic                  cop_rd_wen;
ise_pkg::gpr_addr_t    cop_rd_addr;
ise_pkg::xlen_t        cop_rd_data;

ise_top UUT (
    .g_clk            (g_clk           ),
    .g_resetn         (g_resetn        ),
    .cop_insn_valid   (cop_insn_valid  ),
    .cop_insn_enc     (cop_insn_enc    ),
    .cop_rs1          (cop_rs1         ),
    .cop_result       (cop_result      ),
    .cop_cprs_written (cop_cprs_written),
    .cop_cprs_read    (cop_cprs_read   ),
    .cop_rd_wen       (cop_rd_wen      ),
    .cop_rd_addr      (cop_rd_addr     ),
    .cop_rd_data      (cop_rd_data     )
);

initial
begin
    g_clk = 1'b0;
    forever #50 g_clk = ~g_clk;                 // 100 ns period
end

// --------------------
// Reference state
logic [31:0] shadow [16];                       // Expected CPR contents
logic [2:0]  exp_result;
logic [15:0] exp_written;
logic [15:0] exp_read;
logic        exp_rd_wen;
logic [4:0]  exp_rd_addr;
logic [31:0] exp_rd_data;
logic [31:0] rng_state;
string       test_name;

function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
    return rng_state;
endfunction

// Register form: crs2, crs1, funct3, rd, opcode
function automatic logic [31:0] enc_reg(logic [2:0] f3, logic [4:0] rd,
                                        logic [3:0] crs1, logic [3:0] crs2);
    return {9'b0, crs2, crs1, f3, rd, 7'b0001011};
endfunction

// Immediate form, imm in the top half
function automatic logic [31:0] enc_imm(logic [2:0] f3, logic [3:0] crd, logic [15:0] imm);
    return {imm, 1'b0, f3, 1'b0, crd, 7'b0001011};
endfunction

task automatic fail_now(string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "Stopping on first error");
endtask

task automatic check_eq(string field, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected)
        else fail_now($sformatf("FAIL %s %s: expected %h actual %h",
                                test_name, field, expected, actual));
endtask

task automatic check_outputs();
    check_eq("result",  32'(exp_result),  32'(cop_result));
    check_eq("written", 32'(exp_written), 32'(cop_cprs_written));
    check_eq("read",    32'(exp_read),    32'(cop_cprs_read));
    check_eq("rd_wen",  32'(exp_rd_wen),  32'(cop_rd_wen));
    check_eq("rd_addr", 32'(exp_rd_addr), 32'(cop_rd_addr));
    check_eq("rd_data", exp_rd_data,      cop_rd_data);
endtask

// Expected outputs and shadow update for one valid instruction
task automatic predict(logic [31:0] enc, logic [31:0] rs1);
    logic [2:0]  f3;
    logic [3:0]  crd;
    logic [3:0]  crs1;
    logic [3:0]  crs2;
    logic [31:0] old_crd;
    logic        legal;
    logic        move;
    f3      = enc[14:12];
    crd     = enc[10:7];
    crs1    = enc[18:15];
    crs2    = enc[22:19];
    old_crd = shadow[crd];
    legal   = (enc[6:0] == 7'b0001011) && (f3 <= 3'd5)
           && (f3 >= 3'd4 || enc[31:23] == 9'd0)
           && (f3 == 3'd0 || !enc[11]);
    exp_result  = legal ? 3'b000 : 3'b010;
    exp_written = 16'h0;
    exp_read    = 16'h0;
    exp_rd_wen  = 1'b0;
    exp_rd_addr = 5'd0;
    exp_rd_data = 32'h0;
    if (legal)
    begin
        case (f3)
            3'd0:
            begin
                exp_read    = 16'h0001 << crs1;
                exp_rd_wen  = 1'b1;
                exp_rd_addr = enc[11:7];
                exp_rd_data = shadow[crs1];
            end
            3'd1:
            begin
                exp_written = 16'h0001 << crd;
                shadow[crd] = rs1;
            end
            3'd2, 3'd3:
            begin
                exp_read = (16'h0001 << crs1) | (16'h0001 << crs2);
                move     = (shadow[crs2] == 32'h0) ^ (f3 == 3'd3);   // cmovn inverts
                if (move)
                begin
                    exp_written = 16'h0001 << crd;
                    shadow[crd] = shadow[crs1];
                end
            end
            3'd4:
            begin
                exp_read    = 16'h0001 << crd;
                exp_written = 16'h0001 << crd;
                shadow[crd] = {enc[31:16], old_crd[15:0]};
            end
            default:
            begin
                exp_read    = 16'h0001 << crd;
                exp_written = 16'h0001 << crd;
                shadow[crd] = {old_crd[31:16], enc[31:16]};
            end
        endcase
    end
endtask

// Presents one instruction, results show one edge later
task automatic run_insn(string name, logic [31:0] enc, logic [31:0] rs1);
    test_name      = name;
    cop_insn_valid = 1'b1;
    cop_insn_enc   = enc;
    cop_rs1        = rs1;
    predict(enc, rs1);
    @(posedge g_clk);
    #5;
    cop_insn_valid = 1'b0;
    check_outputs();
endtask

task automatic read_back(string name, logic [3:0] crs);
    logic [31:0] r;
    r = next_rand();
    run_insn(name, enc_reg(3'b000, r[12:8], crs, r[3:0]), next_rand());
endtask

task automatic check_all_cprs(string name);
    for (int i = 0; i < 16; i++)
    begin
        read_back(name, 4'(i));
    end
endtask

// Garbage on the bus while valid stays low
task automatic idle(int n);
    test_name = "idle_hold";
    repeat (n)
    begin
        cop_insn_enc = next_rand();
        cop_rs1      = next_rand();
        @(posedge g_clk);
        #5;
        check_outputs();
    end
endtask

// --------------------
// Protocol checks
a_hold_when_idle: assert property (@(posedge g_clk) disable iff (!g_resetn)
    !$past(cop_insn_valid) |-> (cop_result == $past(cop_result)
        && cop_cprs_written == $past(cop_cprs_written)
        && cop_cprs_read == $past(cop_cprs_read)
        && cop_rd_wen == $past(cop_rd_wen)
        && cop_rd_addr == $past(cop_rd_addr)
        && cop_rd_data == $past(cop_rd_data)))
    else fail_now("Outputs changed on a cycle without a valid instruction");

a_exception_quiet: assert property (@(posedge g_clk) disable iff (!g_resetn)
    (cop_result == ise_pkg::RESULT_DECODE_EXCEPTION)
        |-> (cop_cprs_written == '0 && cop_cprs_read == '0 && !cop_rd_wen))
    else fail_now("Decode exception reported together with register activity");

initial
begin
    #(TOTAL_STEPS * 100 * 2);
    fail_now("Timeout: the tests did not finish in the expected time");
end

// --------------------
// Stimulus
initial
begin
    logic [31:0] r;
    logic [31:0] v;
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  c;
    string       nm;
    rng_state      = 32'd53542;
    g_resetn       = 1'b0;
    cop_insn_valid = 1'b0;
    cop_insn_enc   = 32'h0;
    cop_rs1        = 32'h0;
    for (int i = 0; i < 16; i++)
    begin
        shadow[i] = 32'h0;                      // Reset clears every CPR
    end
    exp_result  = 3'b000;
    exp_written = 16'h0;
    exp_read    = 16'h0;
    exp_rd_wen  = 1'b0;
    exp_rd_addr = 5'd0;
    exp_rd_data = 32'h0;
    repeat (RESET_CYCLES) @(posedge g_clk);
    #5;
    g_resetn  = 1'b1;
    test_name = "reset";
    check_outputs();
    @(posedge g_clk);
    #5;
    check_all_cprs("reset_readback");

    // Write then read straight back, a gap now and then
    for (int i = 0; i < N_PAIRS; i++)
    begin
        r = next_rand();
        a = r[23:20];
        run_insn("mv2cop", enc_reg(3'b001, {1'b0, a}, r[3:0], r[7:4]), next_rand());
        read_back("mv2gpr", a);
        if (i % 4 == 3)
        begin
            idle(2);
        end
    end

    // Half-word loads
    for (int i = 0; i < N_HALF; i++)
    begin
        r = next_rand();
        a = r[11:8];
        run_insn("half_seed", enc_reg(3'b001, {1'b0, a}, 4'h0, 4'h0), next_rand());
        run_insn("lui", enc_imm(3'b100, a, r[31:16]), next_rand());
        read_back("lui_check", a);
        r = next_rand();
        run_insn("lli", enc_imm(3'b101, a, r[15:0]), next_rand());
        read_back("lli_check", a);
    end

    // Distinct dst, src and condition CPRs, all four move outcomes
    for (int i = 0; i < N_CMOV; i++)
    begin
        r  = next_rand();
        a  = r[3:0];
        b  = a + 4'd5;
        c  = a + 4'd10;
        v  = (i % 2 == 0) ? 32'h0 : (next_rand() | 32'h1);
        nm = (i % 4 < 2) ? "cmov" : "cmovn";
        run_insn("cmov_src", enc_reg(3'b001, {1'b0, b}, 4'h0, 4'h0), next_rand());
        run_insn("cmov_cond", enc_reg(3'b001, {1'b0, c}, 4'h0, 4'h0), v);
        run_insn("cmov_dst", enc_reg(3'b001, {1'b0, a}, 4'h0, 4'h0), next_rand());
        run_insn(nm, enc_reg((i % 4 < 2) ? 3'b010 : 3'b011, {1'b0, a}, b, c), next_rand());
        read_back("cmov_check", a);
    end

    // Illegal encodings must leave every CPR alone
    run_insn("bad_opcode", enc_reg(3'b001, 5'd3, 4'd1, 4'd2) ^ 32'h20, next_rand());
    run_insn("bad_f3_110", enc_reg(3'b110, 5'd4, 4'd1, 4'd2), next_rand());
    run_insn("bad_f3_111", enc_reg(3'b111, 5'd5, 4'd3, 4'd4), next_rand());
    run_insn("bad_hi_cmov", enc_reg(3'b010, 5'd6, 4'd7, 4'd8) | 32'h0080_0000, next_rand());
    run_insn("bad_hi_mv2gpr", enc_reg(3'b000, 5'd9, 4'd1, 4'd0) | 32'h8000_0000, next_rand());
    run_insn("bad_crd_mv2cop", enc_reg(3'b001, 5'b10101, 4'd0, 4'd0), next_rand());
    run_insn("bad_crd_lui", enc_imm(3'b100, 4'd6, 16'hbeef) | 32'h0800, next_rand());
    check_all_cprs("bad_readback");

    read_back("idle_last", 4'd9);
    idle(3);                                    // Outputs keep the last result

    $display("Simulation PASSED");
    $finish;
end

endmodule

/* compile.f */
+incdir+include
hw/ise_pkg.sv
hw/ise_decoder.sv
hw/ise_cpr_file.sv
hw/ise_execute.sv
hw/ise_top.sv
bench/ise_tb.sv

/* hw/ise_cpr_file.sv */
`timescale 1ns/10ps

`include "ise_cfg.svh"

module ise_cpr_file (
    input  logic                g_clk,          // Global clock
    input  logic                g_resetn,       // Sync reset, active low

    input  ise_pkg::cpr_addr_t  rd0_addr,       // Read port 0 address
    output ise_pkg::xlen_t      rd0_data,       // Read port 0 data

    input  ise_pkg::cpr_addr_t  rd1_addr,       // Read port 1 address
    output ise_pkg::xlen_t      rd1_data,       // Read port 1 data

    input  logic                wen,            // Write enable
    input  ise_pkg::cpr_addr_t  waddr,          // Write address
    input  ise_pkg::xlen_t      wdata           // Write data
);

// --------------------
// Storage

// Sixteen CPRs, all state of the coprocessor lives here
ise_pkg::xlen_t cprs [`ISE_NUM_CPRS];

// Cleared on reset so reads after reset are defined
always_ff @(posedge g_clk)
begin
    if (!g_resetn)
    begin
        for (int i = 0; i < `ISE_NUM_CPRS; i++)
        begin
            cprs[i] <= '0;
        end
    end
    else if (wen)
    begin
        cprs[waddr] <= wdata;                   // Visible next cycle
    end
end

// --------------------
// Read ports

// Combinational, no bypass of a same-edge write
assign rd0_data = cprs[rd0_addr];
assign rd1_data = cprs[rd1_addr];

// --------------------
// Checks

// Execute stage must never write through an undefined index
property p_waddr_known;
    @(posedge g_clk) disable iff (!g_resetn)
        wen |-> !$isunknown(waddr);
endproperty

a_waddr_known: assert property (p_waddr_known)
    else $error("CPR write with unknown address");

endmodule

/* hw/ise_decoder.sv */
`timescale 1ns/10ps

`include "ise_cfg.svh"

module ise_decoder (
    input  logic                insn_valid,     // Instruction strobe
    input  ise_pkg::xlen_t      insn_enc,       // Raw 32-bit encoding

    output logic                dec_valid_op,   // Legal encoding seen
    output ise_pkg::ise_op_t    dec_op,         // Operation from funct3
    output ise_pkg::gpr_addr_t  dec_rd,         // GPR destination
    output ise_pkg::cpr_addr_t  dec_crd,        // CPR destination
    output ise_pkg::cpr_addr_t  dec_crs1,       // CPR source 1
    output ise_pkg::cpr_addr_t  dec_crs2,       // CPR source 2
    output ise_pkg::cpr_addr_t  cpr_rd1_addr,   // Address for read port 1
    output ise_pkg::imm16_t     dec_imm         // Half-word immediate
);

// --------------------
// Field extraction

// Encoding forced to zero when no instruction is presented
ise_pkg::xlen_t encoded;
assign encoded = insn_enc & {`ISE_XLEN{insn_valid}};

logic [6:0] opcode;
logic [2:0] funct3;
logic       rd_msb;                             // Bit 11, outside crd
logic       hi_bits_zero;                       // Bits 31:23 all clear

assign opcode       = encoded[`ISE_OPC_HI:`ISE_OPC_LO];
assign funct3       = encoded[`ISE_F3_HI:`ISE_F3_LO];
assign rd_msb       = encoded[`ISE_RD_HI];
assign hi_bits_zero = ~|encoded[`ISE_ZERO_HI:`ISE_ZERO_LO];

assign dec_rd   = encoded[`ISE_RD_HI:`ISE_RD_LO];
assign dec_crd  = encoded[`ISE_RD_LO+`ISE_CPR_ADDR_W-1:`ISE_RD_LO];
assign dec_crs1 = encoded[`ISE_CRS1_HI:`ISE_CRS1_LO];
assign dec_crs2 = encoded[`ISE_CRS2_HI:`ISE_CRS2_LO];
assign dec_imm  = encoded[`ISE_IMM_HI:`ISE_IMM_LO];

// Out-of-range funct3 values are caught by the legality check below
assign dec_op   = ise_pkg::ise_op_t'(funct3);

// --------------------
// Legality

logic opcode_ok;
logic funct3_ok;
logic zero_ok;
logic crd_ok;
logic reg_form;                                 // mv2gpr .. cmovn
logic has_crd;                                  // Writes or reads crd

assign opcode_ok = (opcode == `ISE_OPCODE);
assign funct3_ok = (funct3 <= 3'b101);          // 110 and 111 unused

// Register-only forms keep the upper bits clear
assign reg_form  = (funct3 <= 3'b011);
assign zero_ok   = hi_bits_zero || !reg_form;

// Every op but mv2gpr targets a CPR, only four rd bits are meaningful
assign has_crd   = (funct3 != 3'b000);
assign crd_ok    = !(has_crd && rd_msb);

// Gated encoding carries a zero opcode while the strobe is low
assign dec_valid_op = opcode_ok && funct3_ok && zero_ok && crd_ok;

// --------------------
// Read port 1 address

// lui / lli merge into the old crd value, everything else reads crs1
always_comb
begin
    case (dec_op)
        ise_pkg::OP_LUI,
        ise_pkg::OP_LLI: cpr_rd1_addr = dec_crd;
        default:         cpr_rd1_addr = dec_crs1;
    endcase
end

// A legal op is only ever flagged while the strobe is high
always_comb
begin
    if (!insn_valid)
    begin
        assert (!dec_valid_op)
            else $error("Decoder flagged a valid op with insn_valid low");
    end
end

endmodule

/* hw/ise_execute.sv */
`timescale 1ns/10ps

`include "ise_cfg.svh"

module ise_execute (
    input  logic                   g_clk,            // Global clock
    input  logic                   g_resetn,         // Sync reset, active low

    input  logic                   insn_valid,       // Instruction strobe
    input  ise_pkg::xlen_t         rs1,              // RISC-V rs1 value

    // From the decoder
    input  logic                   dec_valid_op,
    input  ise_pkg::ise_op_t       dec_op,
    input  ise_pkg::gpr_addr_t     dec_rd,
    input  ise_pkg::cpr_addr_t     dec_crd,
    input  ise_pkg::cpr_addr_t     dec_crs1,
    input  ise_pkg::cpr_addr_t     dec_crs2,
    input  ise_pkg::imm16_t        dec_imm,

    // From the CPR file
    input  ise_pkg::xlen_t         crs2_data,        // CPR[crs2]
    input  ise_pkg::xlen_t         rd1_data,         // CPR[crs1] or CPR[crd]

    // Registered results
    output ise_pkg::ise_result_t   cop_result,
    output ise_pkg::cpr_mask_t     cop_cprs_written,
    output ise_pkg::cpr_mask_t     cop_cprs_read,
    output logic                   cop_rd_wen,
    output ise_pkg::gpr_addr_t     cop_rd_addr,
    output ise_pkg::xlen_t         cop_rd_data,

    // CPR write port
    output logic                   cpr_wen,
    output ise_pkg::cpr_addr_t     cpr_waddr,
    output ise_pkg::xlen_t         cpr_wdata
);

// --------------------
// Register masks

ise_pkg::cpr_mask_t crd_bit;                     // One-hot of crd
ise_pkg::cpr_mask_t crs1_bit;
ise_pkg::cpr_mask_t crs2_bit;
ise_pkg::cpr_mask_t wr_mask;                     // Set only on a real write

assign crd_bit  = ise_pkg::cpr_mask_t'(1) << dec_crd;
assign crs1_bit = ise_pkg::cpr_mask_t'(1) << dec_crs1;
assign crs2_bit = ise_pkg::cpr_mask_t'(1) << dec_crs2;
assign wr_mask  = cpr_wen ? crd_bit : '0;

// --------------------
// CPR write side

logic crs2_zero;                                 // Move condition source
logic do_exec;                                   // Legal op this cycle

assign crs2_zero = (crs2_data == '0);
assign do_exec   = insn_valid && dec_valid_op;
assign cpr_waddr = dec_crd;                      // Every CPR write hits crd

always_comb
begin
    cpr_wen   = 1'b0;
    cpr_wdata = rd1_data;
    case (dec_op)
        ise_pkg::OP_MV2COP:
        begin
            cpr_wen   = 1'b1;
            cpr_wdata = rs1;                     // GPR value straight in
        end
        ise_pkg::OP_CMOV:  cpr_wen = crs2_zero;  // Data is CPR[crs1]
        ise_pkg::OP_CMOVN: cpr_wen = !crs2_zero;
        ise_pkg::OP_LUI:
        begin
            cpr_wen   = 1'b1;
            cpr_wdata = {dec_imm, rd1_data[`ISE_XLEN/2-1:0]};
        end
        ise_pkg::OP_LLI:
        begin
            cpr_wen   = 1'b1;
            cpr_wdata = {rd1_data[`ISE_XLEN-1:`ISE_XLEN/2], dec_imm};
        end
        default: cpr_wen = 1'b0;                 // mv2gpr leaves CPRs alone
    endcase
    if (!do_exec)
    begin
        cpr_wen = 1'b0;                          // Nothing lands when invalid
    end
end

// --------------------
// Output registers

// Outputs hold between valid instructions
always_ff @(posedge g_clk)
begin
    if (!g_resetn)
    begin
        cop_result       <= ise_pkg::RESULT_SUCCESS;
        cop_cprs_written <= '0;
        cop_cprs_read    <= '0;
        cop_rd_wen       <= 1'b0;
        cop_rd_addr      <= '0;
        cop_rd_data      <= '0;
    end
    else if (insn_valid)
    begin
        // Wipe the last result, then load the new one
        cop_result       <= ise_pkg::RESULT_SUCCESS;
        cop_cprs_written <= '0;
        cop_cprs_read    <= '0;
        cop_rd_wen       <= 1'b0;
        cop_rd_addr      <= '0;
        cop_rd_data      <= '0;
        if (!dec_valid_op)
        begin
            cop_result <= ise_pkg::RESULT_DECODE_EXCEPTION;
        end
        else
        begin
            cop_cprs_written <= wr_mask;         // Empty on a skipped cmov
            case (dec_op)
                ise_pkg::OP_MV2GPR:
                begin
                    cop_cprs_read <= crs1_bit;
                    cop_rd_wen    <= 1'b1;
                    cop_rd_addr   <= dec_rd;
                    cop_rd_data   <= rd1_data;
                end
                ise_pkg::OP_CMOV,
                ise_pkg::OP_CMOVN: cop_cprs_read <= crs1_bit | crs2_bit;
                ise_pkg::OP_LUI,
                ise_pkg::OP_LLI:   cop_cprs_read <= crd_bit;   // Old value merged
                default:           cop_cprs_read <= '0;        // mv2cop reads no CPR
            endcase
        end
    end
end

// --------------------
// Checks

// A GPR write-back only comes from a successful instruction
a_rd_wen_success: assert property (@(posedge g_clk) disable iff (!g_resetn)
    cop_rd_wen |-> (cop_result == ise_pkg::RESULT_SUCCESS))
    else $error("GPR write-back reported with a failing result");

// No kept instruction writes more than one CPR
a_single_write: assert property (@(posedge g_clk) disable iff (!g_resetn)
    $onehot0(cop_cprs_written))
    else $error("More than one CPR flagged as written");

endmodule

/* hw/ise_pkg.sv */
package ise_pkg;

`include "ise_cfg.svh"

// --------------------
// Vector types

typedef logic [`ISE_XLEN-1:0]       xlen_t;      // One data word
typedef logic [`ISE_CPR_ADDR_W-1:0] cpr_addr_t;  // CPR index
typedef logic [`ISE_GPR_ADDR_W-1:0] gpr_addr_t;  // GPR index
typedef logic [`ISE_NUM_CPRS-1:0]   cpr_mask_t;  // One bit per CPR

// Immediate spans the whole upper half of the encoding
typedef logic [`ISE_IMM_HI-`ISE_IMM_LO:0] imm16_t;

// --------------------
// Operation select

// Values follow funct3 directly
typedef enum logic [2:0] {
    OP_MV2GPR = 3'b000,     // CPR to GPR
    OP_MV2COP = 3'b001,     // GPR to CPR
    OP_CMOV   = 3'b010,     // Move if crs2 is zero
    OP_CMOVN  = 3'b011,     // Move if crs2 is nonzero
    OP_LUI    = 3'b100,     // Load upper half
    OP_LLI    = 3'b101      // Load lower half
} ise_op_t;

// --------------------
// Result codes

// Only the codes reachable by the kept instructions
typedef enum logic [2:0] {
    RESULT_SUCCESS          = 3'b000,
    RESULT_DECODE_EXCEPTION = 3'b010
} ise_result_t;

endpackage

/* hw/ise_top.sv */
`timescale 1ns/10ps

module ise_top (
    input  logic                   g_clk,            // Global clock
    input  logic                   g_resetn,         // Sync reset, active low

    input  logic                   cop_insn_valid,   // Instruction valid
    input  ise_pkg::xlen_t         cop_insn_enc,     // Encoded instruction
    input  ise_pkg::xlen_t         cop_rs1,          // rs1 source data

    output ise_pkg::ise_result_t   cop_result,       // Execution result
    output ise_pkg::cpr_mask_t     cop_cprs_written, // CPRs written
    output ise_pkg::cpr_mask_t     cop_cprs_read,    // CPRs read
    output logic                   cop_rd_wen,       // GPR write enable
    output ise_pkg::gpr_addr_t     cop_rd_addr,      // GPR write address
    output ise_pkg::xlen_t         cop_rd_data       // GPR write data
);

// --------------------
// Decode outputs
logic                dec_valid_op;
ise_pkg::ise_op_t    dec_op;
ise_pkg::gpr_addr_t  dec_rd;
ise_pkg::cpr_addr_t  dec_crd;
ise_pkg::cpr_addr_t  dec_crs1;
ise_pkg::cpr_addr_t  dec_crs2;
ise_pkg::cpr_addr_t  cpr_rd1_addr;
ise_pkg::imm16_t     dec_imm;

// CPR file ports
ise_pkg::xlen_t      crs2_data;
ise_pkg::xlen_t      rd1_data;
logic                cpr_wen;
ise_pkg::cpr_addr_t  cpr_waddr;
ise_pkg::xlen_t      cpr_wdata;

ise_decoder i_decoder (
    .insn_valid   (cop_insn_valid),
    .insn_enc     (cop_insn_enc  ),
    .dec_valid_op (dec_valid_op  ),
    .dec_op       (dec_op        ),
    .dec_rd       (dec_rd        ),
    .dec_crd      (dec_crd       ),
    .dec_crs1     (dec_crs1      ),
    .dec_crs2     (dec_crs2      ),
    .cpr_rd1_addr (cpr_rd1_addr  ),
    .dec_imm      (dec_imm       )
);

// Port 0 always serves crs2, port 1 is steered by the decoder
ise_cpr_file i_cpr_file (
    .g_clk    (g_clk       ),
    .g_resetn (g_resetn    ),
    .rd0_addr (dec_crs2    ),
    .rd0_data (crs2_data   ),
    .rd1_addr (cpr_rd1_addr),
    .rd1_data (rd1_data    ),
    .wen      (cpr_wen     ),
    .waddr    (cpr_waddr   ),
    .wdata    (cpr_wdata   )
);

ise_execute i_execute (
    .g_clk            (g_clk           ),
    .g_resetn         (g_resetn        ),
    .insn_valid       (cop_insn_valid  ),
    .rs1              (cop_rs1         ),
    .dec_valid_op     (dec_valid_op    ),
    .dec_op           (dec_op          ),
    .dec_rd           (dec_rd          ),
    .dec_crd          (dec_crd         ),
    .dec_crs1         (dec_crs1        ),
    .dec_crs2         (dec_crs2        ),
    .dec_imm          (dec_imm         ),
    .crs2_data        (crs2_data       ),
    .rd1_data         (rd1_data        ),
    .cop_result       (cop_result      ),
    .cop_cprs_written (cop_cprs_written),
    .cop_cprs_read    (cop_cprs_read   ),
    .cop_rd_wen       (cop_rd_wen      ),
    .cop_rd_addr      (cop_rd_addr     ),
    .cop_rd_data      (cop_rd_data     ),
    .cpr_wen          (cpr_wen         ),
    .cpr_waddr        (cpr_waddr       ),
    .cpr_wdata        (cpr_wdata       )
);

endmodule

/* include/ise_cfg.svh */
`ifndef ISE_CFG_SVH
`define ISE_CFG_SVH

// Datapath and register file sizes
`define ISE_XLEN        32      // Data word width
`define ISE_NUM_CPRS    16      // Coprocessor registers
`define ISE_CPR_ADDR_W  4       // CPR index width
`define ISE_GPR_ADDR_W  5       // RISC-V GPR index width

// Major opcode, custom-0 space
`define ISE_OPCODE      7'b0001011
`define ISE_OPC_LO      0
`define ISE_OPC_HI      6

// --------------------
// Instruction fields
`define ISE_RD_LO       7       // rd, low four bits double as crd
`define ISE_RD_HI       11
`define ISE_F3_LO       12      // funct3 selects the operation
`define ISE_F3_HI       14
`define ISE_CRS1_LO     15
`define ISE_CRS1_HI     18
`define ISE_CRS2_LO     19
`define ISE_CRS2_HI     22
`define ISE_IMM_LO      16      // Half-word immediate for lui / lli
`define ISE_IMM_HI      31
`define ISE_ZERO_LO     23      // Must be zero on register-only forms
`define ISE_ZERO_HI     31

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f compile.f --top-module ise_tb -Mdir obj_dir -o ise_sim \
    && ./obj_dir/ise_sim \
    || exit 1
